/* common/armPkg.sv */
`default_nettype none

package armPkg;

  // ==========================================================================
  // Widths that carry a meaning
  // ==========================================================================

  // Data or address word
  typedef logic [31:0] word_t;
  // Register number, R0..R15
  typedef logic [3:0]  regIdx_t;
  // Data-processing opcode, instruction bits 24:21
  typedef logic [3:0]  aluOp_t;
  // Shift kind, instruction bits 6:5
  typedef logic [1:0]  shiftType_t;

  // Only the "always" condition is executed
  localparam logic [3:0] condAlways = 4'b1110;

  // Supported data-processing opcodes
  localparam aluOp_t opAnd = 4'b0000;
  localparam aluOp_t opEor = 4'b0001;
  localparam aluOp_t opSub = 4'b0010;
  localparam aluOp_t opAdd = 4'b0100;
  localparam aluOp_t opOrr = 4'b1100;
  localparam aluOp_t opMov = 4'b1101;

  // Shift kinds for a register operand
  localparam shiftType_t shLsl = 2'b00;
  localparam shiftType_t shLsr = 2'b01;
  localparam shiftType_t shAsr = 2'b10;
  localparam shiftType_t shRor = 2'b11;

  // ==========================================================================
  // Stage structs
  // ==========================================================================

  // Decode to execute
  typedef struct packed {
    logic       valid;
    logic       regWrite;
    logic       isLoad;
    logic       isStore;
    logic       isByte;
    logic       useImm;
    aluOp_t     aluOp;
    shiftType_t shiftType;
    logic [4:0] shiftAmount;
    regIdx_t    rd;
    regIdx_t    rn;
    regIdx_t    rm;
    word_t      rnValue;
    word_t      rmValue;
    // Store data
    word_t      rdValue;
    // Rotated immediate or load/store offset
    word_t      imm;
  } execCtrl_t;

  // Execute to memory stage
  typedef struct packed {
    logic    valid;
    logic    regWrite;
    logic    isLoad;
    logic    isStore;
    logic    isByte;
    regIdx_t rd;
    word_t   aluOut;
    word_t   storeData;
  } memStage_t;

  // Writeback bus back to register file and bypass
  typedef struct packed {
    logic    valid;
    logic    regWrite;
    regIdx_t rd;
    word_t   result;
  } wbBus_t;

endpackage

`default_nettype wire

/* execute/aluShifter.sv */
`timescale 1ns/1ns
`default_nettype none

module aluShifter import armPkg::*; (
  input  word_t      operandA,
  input  word_t      operandB,
  input  shiftType_t shiftType,
  input  logic [4:0] shiftAmount,
  input  aluOp_t     aluOp,
  output word_t      aluResult
);

  word_t       shifted;
  logic [63:0] rorWide;

  // ==========================================================================
  // Barrel shifter
  // ==========================================================================

  // Rotate through a doubled copy, so amount 0 is a plain pass
  assign rorWide = {operandB, operandB} >> shiftAmount;

  always_comb begin
    case (shiftType)
      shLsl: begin
        shifted = operandB << shiftAmount;
      end
      shLsr: begin
        shifted = operandB >> shiftAmount;
      end
      shAsr: begin
        // Sign fill from bit 31
        shifted = word_t'($signed(operandB) >>> shiftAmount);
      end
      shRor: begin
        shifted = rorWide[31:0];
      end
      default: begin
        shifted = operandB;
      end
    endcase
  end

  // ==========================================================================
  // ALU
  // ==========================================================================

  always_comb begin
    case (aluOp)
      opAnd:   aluResult = operandA & shifted;
      opEor:   aluResult = operandA ^ shifted;
      opSub:   aluResult = operandA - shifted;
      opAdd:   aluResult = operandA + shifted;
      opOrr:   aluResult = operandA | shifted;
      // MOV ignores rn
      opMov:   aluResult = shifted;
      default: aluResult = '0;
    endcase
  end

endmodule

`default_nettype wire

/* decode/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile import armPkg::*; #(
  parameter int NumRegs = 15
) (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t readA,
  input  regIdx_t readB,
  input  regIdx_t readC,
  input  wbBus_t  wb,
  output word_t   dataA,
  output word_t   dataB,
  output word_t   dataC
);

  word_t regs [NumRegs];
  logic  writeEn;

  // R15 is not held here, writes to it are dropped
  assign writeEn = wb.valid && wb.regWrite && (wb.rd < NumRegs);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // Read with write-through of this cycle's result
  function automatic word_t readPort(regIdx_t idx);
    if (writeEn && wb.rd == idx) begin
      return wb.result;
    end
    return (idx < NumRegs) ? regs[idx] : '0;
  endfunction

  assign dataA = readPort(readA);
  assign dataB = readPort(readB);
  assign dataC = readPort(readC);

endmodule

`default_nettype wire

/* decode/decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage import armPkg::*; #(
  parameter int NumRegs = 15
) (
  input  logic      clk,
  input  logic      reset,
  input  word_t     InstrF,
  input  wbBus_t    wb,
  output execCtrl_t ctrlE
);

  word_t       instrD;
  logic        validD;
  logic        isDp;
  logic        isMem;
  logic        immOp;
  logic        dpSupported;
  logic        memSupported;
  logic        loadBit;
  logic [63:0] immWide;
  word_t       rotImm;
  word_t       rnValue;
  word_t       rmValue;
  word_t       rdValue;

  // Decode register, only the valid bit is cleared
  always_ff @(posedge clk) begin
    instrD <= InstrF;
    validD <= ~reset;
  end

  // Instruction class from bits 27:26
  assign isDp    = instrD[27:26] == 2'b00;
  assign isMem   = instrD[27:26] == 2'b01;
  assign immOp   = instrD[25];
  assign loadBit = instrD[20];

  // Data processing: only the six opcodes, register form needs an immediate shift
  assign dpSupported = isDp && (immOp || !instrD[4]) &&
                       (instrD[24:21] == opAnd || instrD[24:21] == opEor ||
                        instrD[24:21] == opSub || instrD[24:21] == opAdd ||
                        instrD[24:21] == opOrr || instrD[24:21] == opMov);

  // Single transfer: immediate offset, pre-indexed, offset added, no write-back
  assign memSupported = isMem && !immOp && instrD[24] && instrD[23] && !instrD[21];

  // 8-bit immediate rotated right by twice bits 11:8
  assign immWide = {24'b0, instrD[7:0], 24'b0, instrD[7:0]} >> {instrD[11:8], 1'b0};
  assign rotImm  = immWide[31:0];

  registerFile #(
    .NumRegs(NumRegs)
  ) regs (
    .clk  (clk),
    .reset(reset),
    .readA(instrD[19:16]),
    .readB(instrD[3:0]),
    .readC(instrD[15:12]),
    .wb   (wb),
    .dataA(rnValue),
    .dataB(rmValue),
    .dataC(rdValue)
  );

  always_comb begin
    ctrlE.valid    = validD && instrD[31:28] == condAlways && (dpSupported || memSupported);
    ctrlE.regWrite = dpSupported || (memSupported && loadBit);
    ctrlE.isLoad   = memSupported && loadBit;
    ctrlE.isStore  = memSupported && !loadBit;
    ctrlE.isByte   = memSupported && instrD[22];
    ctrlE.useImm   = isMem || immOp;
    // Memory ops get their add in execute
    ctrlE.aluOp    = instrD[24:21];
    // Immediate forms take no shift
    ctrlE.shiftType   = (isDp && !immOp) ? instrD[6:5] : shLsl;
    ctrlE.shiftAmount = (isDp && !immOp) ? instrD[11:7] : 5'd0;
    ctrlE.rd      = instrD[15:12];
    ctrlE.rn      = instrD[19:16];
    ctrlE.rm      = instrD[3:0];
    ctrlE.rnValue = rnValue;
    ctrlE.rmValue = rmValue;
    ctrlE.rdValue = rdValue;
    ctrlE.imm     = isMem ? {20'b0, instrD[11:0]} : rotImm;
  end

endmodule

`default_nettype wire

/* execute/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage import armPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  execCtrl_t ctrlE,
  input  wbBus_t    wb,
  output memStage_t memM
);

  execCtrl_t ctrlQ;
  word_t     rnFwd;
  word_t     rmFwd;
  word_t     rdFwd;
  word_t     operandB;
  word_t     aluResult;
  aluOp_t    aluOpE;
  logic      isMemOp;

  // ==========================================================================
  // Execute register
  // ==========================================================================

  always_ff @(posedge clk) begin
    ctrlQ <= ctrlE;
    if (reset) begin
      ctrlQ.valid <= 1'b0;
    end
  end

  // ==========================================================================
  // Bypass
  // ==========================================================================

  // Memory stage first, then writeback, then the register value
  // Load data is not ready in the memory stage yet
  function automatic word_t bypass(regIdx_t idx, word_t regValue);
    if (memM.valid && memM.regWrite && !memM.isLoad && memM.rd == idx) begin
      return memM.aluOut;
    end
    if (wb.valid && wb.regWrite && wb.rd == idx) begin
      return wb.result;
    end
    return regValue;
  endfunction

  assign rnFwd = bypass(ctrlQ.rn, ctrlQ.rnValue);
  assign rmFwd = bypass(ctrlQ.rm, ctrlQ.rmValue);
  assign rdFwd = bypass(ctrlQ.rd, ctrlQ.rdValue);

  // Shifted register or immediate
  assign operandB = ctrlQ.useImm ? ctrlQ.imm : rmFwd;

  // Loads and stores compute base plus offset
  assign isMemOp = ctrlQ.isLoad | ctrlQ.isStore;
  assign aluOpE  = isMemOp ? opAdd : ctrlQ.aluOp;

  aluShifter alu (
    .operandA   (rnFwd),
    .operandB   (operandB),
    .shiftType  (ctrlQ.shiftType),
    .shiftAmount(ctrlQ.shiftAmount),
    .aluOp      (aluOpE),
    .aluResult  (aluResult)
  );

  // ==========================================================================
  // Memory stage register
  // ==========================================================================

  always_ff @(posedge clk) begin
    memM.valid     <= ctrlQ.valid;
    memM.regWrite  <= ctrlQ.regWrite;
    memM.isLoad    <= ctrlQ.isLoad;
    memM.isStore   <= ctrlQ.isStore;
    memM.isByte    <= ctrlQ.isByte;
    memM.rd        <= ctrlQ.rd;
    memM.aluOut    <= aluResult;
    memM.storeData <= rdFwd;
    if (reset) begin
      memM.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/resultSelect.sv */
`timescale 1ns/1ns
`default_nettype none

module resultSelect import armPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  memStage_t memM,
  input  word_t     ReadDataM,
  output wbBus_t    wb
);

  memStage_t memW;
  word_t     readDataW;
  logic [7:0] loadByte;
  word_t     loadValue;

  // Writeback register, valid cleared on reset
  always_ff @(posedge clk) begin
    memW      <= memM;
    readDataW <= ReadDataM;
    if (reset) begin
      memW.valid <= 1'b0;
    end
  end

  // Byte lane picked by address bits 1:0
  always_comb begin
    case (memW.aluOut[1:0])
      2'd0:    loadByte = readDataW[7:0];
      2'd1:    loadByte = readDataW[15:8];
      2'd2:    loadByte = readDataW[23:16];
      default: loadByte = readDataW[31:24];
    endcase
  end

  // LDRB is zero-extended
  assign loadValue = memW.isByte ? {24'b0, loadByte} : readDataW;

  assign wb.valid    = memW.valid;
  assign wb.regWrite = memW.regWrite;
  assign wb.rd       = memW.rd;
  assign wb.result   = memW.isLoad ? loadValue : memW.aluOut;

endmodule

`default_nettype wire

/* verilog/armDatapath.sv */
`timescale 1ns/1ns
`default_nettype none

module armDatapath import armPkg::*; #(
  parameter int    NumRegs = 15,
  parameter word_t ResetPc = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  reset,
  input  word_t InstrF,
  input  word_t ReadDataM,
  output word_t PCF,
  output word_t ALUOutM,
  output word_t WriteDataM,
  output logic  MemWriteM
);

  execCtrl_t ctrlE;
  memStage_t memM;
  wbBus_t    wb;
  word_t     pcPlus4F;

  // ==========================================================================
  // Fetch
  // ==========================================================================

  // No branches, so the PC only steps forward
  assign pcPlus4F = PCF + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      PCF <= ResetPc;
    end else begin
      PCF <= pcPlus4F;
    end
  end

  // ==========================================================================
  // Decode, execute and writeback
  // ==========================================================================

  decodeStage #(
    .NumRegs(NumRegs)
  ) decode (
    .clk   (clk),
    .reset (reset),
    .InstrF(InstrF),
    .wb    (wb),
    .ctrlE (ctrlE)
  );

  executeStage execute (
    .clk  (clk),
    .reset(reset),
    .ctrlE(ctrlE),
    .wb   (wb),
    .memM (memM)
  );

  resultSelect result (
    .clk      (clk),
    .reset    (reset),
    .memM     (memM),
    .ReadDataM(ReadDataM),
    .wb       (wb)
  );

  // ==========================================================================
  // Memory stage outputs
  // ==========================================================================

  assign ALUOutM = memM.aluOut;
  // Byte store puts the same byte on every lane
  assign WriteDataM = memM.isByte ? {4{memM.storeData[7:0]}} : memM.storeData;
  assign MemWriteM  = memM.valid & memM.isStore;

endmodule

`default_nettype wire

/* bench/armDatapath_props.sv */
`timescale 1ns/1ns
`default_nettype none

module armDatapathProps import armPkg::*; (
  input logic  clk,
  input logic  reset,
  input word_t PCF,
  input word_t WriteDataM,
  input logic  MemWriteM
);

  // Read by the testbench for its closing count
  int failCount = 0;

  // Pipeline valid bits are clear through reset and one cycle past it
  noStoreAfterReset: assert property (@(posedge clk) reset |=> !MemWriteM)
    else begin
      failCount++;
      $error("memory write seen during reset or in the cycle after it");
    end

  // No branches, so fetch always steps one word
  pcStep: assert property (@(posedge clk) !reset |=> PCF == $past(PCF) + 32'd4)
    else begin
      failCount++;
      $error("PCF did not advance by 4");
    end

  storeDataKnown: assert property (@(posedge clk) MemWriteM |-> !$isunknown(WriteDataM))
    else begin
      failCount++;
      $error("WriteDataM has unknown bits during a store");
    end

endmodule

bind armDatapath armDatapathProps props (.*);

`default_nettype wire

/* bench/armDatapathTb.sv */
`timescale 1ns/1ns
`default_nettype none

module armDatapathTb import armPkg::*; ();

  localparam word_t nopInstr = 32'hE1A0_0000;

  logic  clk = 1'b0;
  logic  reset;
  word_t InstrF;
  word_t ReadDataM;
  word_t PCF;
  word_t ALUOutM;
  word_t WriteDataM;
  logic  MemWriteM;

  // Program and expected stores
  word_t  progMem [256];
  int     progLen;
  word_t  expAddr [128];
  word_t  expData [128];
  int     expIndex [128];
  int     expCount;
  int     storeOff;
  // ISA-level register state while the program is built
  word_t  refRegs [16];
  word_t  dataMem [256];
  integer seed;
  int     storeCount = 0;
  int     errors = 0;
  int     cycleCount = 0;
  int     cycleLimit = 0;

  always #50 clk = ~clk;

  armDatapath UUT (
    .clk       (clk),
    .reset     (reset),
    .InstrF    (InstrF),
    .ReadDataM (ReadDataM),
    .PCF       (PCF),
    .ALUOutM   (ALUOutM),
    .WriteDataM(WriteDataM),
    .MemWriteM (MemWriteM)
  );

  // Instruction and data memories answer in the same cycle
  assign InstrF = (!$isunknown(PCF) && PCF[31:2] < progLen) ? progMem[PCF[9:2]] : nopInstr;
  assign ReadDataM = $isunknown(ALUOutM) ? '0 : dataMem[ALUOutM[9:2]];

  // ==========================================================================
  // ISA rules
  // ==========================================================================

  function automatic word_t rotateRight(word_t value, int amount);
    if (amount % 32 == 0) begin
      return value;
    end
    return (value >> amount) | (value << (32 - amount));
  endfunction

  // Amount 0 leaves the operand as is, for every kind
  function automatic word_t shiftOperand(word_t value, shiftType_t kind, int amount);
    case (kind)
      shLsl:   return value << amount;
      shLsr:   return value >> amount;
      shAsr:   return (value >> amount) | (value[31] ? ~(32'hFFFF_FFFF >> amount) : 32'h0);
      default: return rotateRight(value, amount);
    endcase
  endfunction

  function automatic word_t aluRule(aluOp_t op, word_t a, word_t b);
    case (op)
      opAnd:   return a & b;
      opEor:   return a ^ b;
      opSub:   return a - b;
      opAdd:   return a + b;
      opOrr:   return a | b;
      opMov:   return b;
      default: return '0;
    endcase
  endfunction

  // ==========================================================================
  // Program assembly with expected results
  // ==========================================================================

  task automatic emit(word_t instr);
    progMem[progLen] = instr;
    progLen++;
  endtask

  task automatic dpReg(aluOp_t op, regIdx_t rd, regIdx_t rn, regIdx_t rm,
                       shiftType_t kind, logic [4:0] amount);
    emit({4'hE, 3'b000, op, 1'b0, rn, rd, amount, kind, 1'b0, rm});
    refRegs[rd] = aluRule(op, refRegs[rn], shiftOperand(refRegs[rm], kind, amount));
  endtask

  task automatic dpImm(aluOp_t op, regIdx_t rd, regIdx_t rn, logic [7:0] imm8,
                       logic [3:0] rot);
    emit({4'hE, 3'b001, op, 1'b0, rn, rd, rot, imm8});
    refRegs[rd] = aluRule(op, refRegs[rn], rotateRight({24'b0, imm8}, 2 * rot));
  endtask

  task automatic nop();
    dpReg(opMov, 0, 0, 0, shLsl, 0);
  endtask

  // Load followed by one independent instruction, no interlock in the core
  task automatic loadReg(logic isByte, regIdx_t rd, regIdx_t rn, logic [11:0] offset);
    word_t address;
    word_t memWord;
    address = refRegs[rn] + offset;
    memWord = dataMem[address[9:2]];
    emit({4'hE, 3'b010, 1'b1, 1'b1, isByte, 1'b0, 1'b1, rn, rd, offset});
    refRegs[rd] = isByte ? ((memWord >> (8 * address[1:0])) & 32'hFF) : memWord;
    nop();
  endtask

  task automatic storeReg(logic isByte, regIdx_t rd, regIdx_t rn, logic [11:0] offset);
    emit({4'hE, 3'b010, 1'b1, 1'b1, isByte, 1'b0, 1'b0, rn, rd, offset});
    expAddr[expCount]  = refRegs[rn] + offset;
    expData[expCount]  = isByte ? {4{refRegs[rd][7:0]}} : refRegs[rd];
    expIndex[expCount] = progLen - 1;
    expCount++;
  endtask

  // Word store to the next free slot above the R10 base
  task automatic storeNext(regIdx_t rd);
    storeReg(1'b0, rd, 10, storeOff[11:0]);
    storeOff += 4;
  endtask

  // Producer, consumer and store spaced by gap NOPs
  task automatic chain(int gap, regIdx_t first, regIdx_t second);
    dpReg(opAdd, first, 1, 2, shLsl, 0);
    repeat (gap) nop();
    dpReg(opEor, second, first, 1, shLsl, 3);
    repeat (gap) nop();
    storeNext(second);
  endtask

  task automatic buildProgram();
    aluOp_t aluOps [5] = '{opAdd, opSub, opAnd, opEor, opOrr};
    int     amounts [3] = '{0, 1, 31};
    // Store base 0x200, load base 0x40, two operands
    dpImm(opMov, 10, 0, 8'h02, 4'd12);
    dpImm(opMov, 11, 0, 8'h40, 4'd0);
    dpImm(opMov, 1, 0, 8'hF3, 4'd2);
    dpImm(opMov, 2, 0, 8'h5A, 4'd0);
    foreach (aluOps[i]) begin
      dpReg(aluOps[i], 3, 1, 2, shLsl, 0);
      storeNext(3);
    end
    dpImm(opAdd, 4, 2, 8'hC1, 4'd15);
    storeNext(4);
    // Shifts of a value with both end bits set
    dpImm(opMov, 7, 0, 8'h06, 4'd1);
    for (int kind = 0; kind < 4; kind++) begin
      foreach (amounts[j]) begin
        dpReg(opMov, 8, 0, 7, shiftType_t'(kind), amounts[j][4:0]);
        storeNext(8);
      end
    end
    // Distance one, two, three and fully padded
    chain(0, 5, 6);
    chain(1, 8, 9);
    chain(2, 12, 13);
    chain(4, 14, 3);
    // Word loads, then bytes at every lane
    for (int k = 0; k < 4; k++) begin
      loadReg(1'b0, 12, 11, 12'(4 * k));
      dpReg(opAdd, 13, 12, 2, shLsl, 0);
      storeNext(13);
    end
    for (int k = 0; k < 4; k++) begin
      loadReg(1'b1, 12, 11, 12'(16 + k));
      dpReg(opAdd, 13, 12, 2, shLsl, 0);
      storeNext(13);
    end
    // Byte stores at unaligned addresses
    dpImm(opMov, 9, 0, 8'hA5, 4'd0);
    for (int k = 0; k < 4; k++) begin
      storeReg(1'b1, 9, 10, 12'(12'h100 + k));
    end
    storeReg(1'b1, 1, 10, 12'h105);
  endtask

  // ==========================================================================
  // Checking
  // ==========================================================================

  task automatic reportAndStop(input bit timedOut);
    int total;
    total = errors + UUT.props.failCount;
    $display("Errors: %0d checks, %0d properties; stores seen %0d of %0d",
             errors, UUT.props.failCount, storeCount, expCount);
    if (!timedOut && total == 0 && storeCount == expCount) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // Store monitor, outputs sampled before the edge updates them
  always @(posedge clk) begin
    if (MemWriteM === 1'b1) begin
      assert (storeCount < expCount) else begin
        errors++;
        $display("Unexpected extra store to address %h at time %0t", ALUOutM, $time);
      end
      if (storeCount < expCount) begin
        assert (ALUOutM === expAddr[storeCount]) else begin
          errors++;
          $display("[ERROR] %0t: store %0d address %h, expected %h",
                   $time, storeCount, ALUOutM, expAddr[storeCount]);
        end
        assert (WriteDataM === expData[storeCount]) else begin
          errors++;
          $display("[ERROR] %0t: store %0d data %h, expected %h",
                   $time, storeCount, WriteDataM, expData[storeCount]);
        end
        // Memory stage is three fetches behind the store
        assert (PCF === word_t'(4 * (expIndex[storeCount] + 3))) else begin
          errors++;
          $display("[ERROR] %0t: store %0d seen at PCF %h, expected %h", $time,
                   storeCount, PCF, word_t'(4 * (expIndex[storeCount] + 3)));
        end
        dataMem[ALUOutM[9:2]] <= WriteDataM;
      end
      storeCount++;
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycleCount++;
    end
  end

  initial begin
    @(negedge reset);
    wait (cycleCount >= cycleLimit);
    $display("Timeout after %0d cycles, %0d of %0d stores seen",
             cycleCount, storeCount, expCount);
    reportAndStop(1'b1);
  end

  initial begin
    reset = 1'b1;
    seed = 32'h8eb04310;
    progLen = 0;
    expCount = 0;
    storeOff = 0;
    for (int i = 0; i < 256; i++) begin
      progMem[i] = nopInstr;
      dataMem[i] = $random(seed);
    end
    foreach (refRegs[i]) begin
      refRegs[i] = '0;
    end
    buildProgram();
    cycleLimit = progLen + 20;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    // First fetch after reset
    @(posedge clk);
    assert (PCF === 32'd0) else begin
      errors++;
      $display("[ERROR] %0t: PCF %h after reset, expected 0", $time, PCF);
    end
    wait (storeCount == expCount);
    // A few more cycles to catch stray stores
    repeat (4) @(posedge clk);
    reportAndStop(1'b0);
  end

endmodule

`default_nettype wire

/* build.f */
common/armPkg.sv
execute/aluShifter.sv
decode/registerFile.sv
decode/decodeStage.sv
execute/executeStage.sv
verilog/resultSelect.sv
verilog/armDatapath.sv
bench/armDatapath_props.sv
bench/armDatapathTb.sv

/* Bender.yml */
package:
  name: arm_datapath

sources:
  - common/armPkg.sv
  - execute/aluShifter.sv
  - decode/registerFile.sv
  - decode/decodeStage.sv
  - execute/executeStage.sv
  - verilog/resultSelect.sv
  - verilog/armDatapath.sv
  - target: simulation
    files:
      - bench/armDatapath_props.sv
      - bench/armDatapathTb.sv
